// File: patch_app.f
src/patch_pkg.sv
src/msg_fifo.sv
src/msg_router.sv
src/frame_tracker.sv
src/dram_sequencer.sv
src/patch_app.sv
test/dram_model.sv
test/patch_app_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing -f patch_app.f --top-module patch_app_tb -o sim_patch_app \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_patch_app > sim.log 2>&1
grep -q "Test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: src/dram_sequencer.sv
`timescale 1ns/1ps

module dram_sequencer import patch_pkg::*; #(
  parameter int APP_DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 27,
  parameter logic [ADDR_WIDTH-1:0] START_ADDR = '0
) (
  input  logic                      bus_clk,
  input  logic                      fds_val,
  input  pc_msg_t                   coef_word,
  input  logic                      coef_empty,
  input  logic                      app_rdy,
  input  logic                      app_wdf_rdy,
  input  logic                      rd_high,
  input  logic                      rd_overflow,
  input  logic                      pix_overflow,
  input  logic                      frame_start,
  output logic                      coef_ack,
  output logic                      app_en,
  output logic                      dram_read,
  output logic [ADDR_WIDTH-1:0]     app_addr,
  output logic                      app_wdf_wren,
  output logic                      app_wdf_end,
  output logic [APP_DATA_WIDTH-1:0] app_wdf_data,
  output logic                      error
);

  localparam logic [2:0] S_GATHER = 3'd0;
  localparam logic [2:0] S_WR_WAIT = 3'd1;   // command and low beat outstanding
  localparam logic [2:0] S_WR2 = 3'd2;       // high beat outstanding
  localparam logic [2:0] S_READING = 3'd3;
  localparam logic [2:0] S_THROTTLED = 3'd4;
  localparam logic [2:0] S_BETWEEN_FRAMES = 3'd5;
  localparam logic [2:0] S_ERROR = 3'd6;

  localparam int IDX_W = $clog2(WORDS_PER_GROUP);
  localparam logic [IDX_W-1:0] LAST_WORD = IDX_W'(WORDS_PER_GROUP - 1);
  localparam logic [ADDR_WIDTH-1:0] STEP = ADDR_WIDTH'(ADDR_INC);

  logic [2:0] state;
  logic [IDX_W-1:0] word_idx;
  logic [2*APP_DATA_WIDTH-1:0] grp_data;  // word k sits at bit 32k
  logic grp_last;
  logic [ADDR_WIDTH-1:0] wr_addr;   // where the next group goes
  logic [ADDR_WIDTH-1:0] end_addr;  // address of the last group written
  logic cmd_done;
  logic grp_full;

  assign coef_ack = (state == S_GATHER) && !coef_empty;
  assign grp_full = coef_ack && word_idx == LAST_WORD;
  assign cmd_done = !app_en || app_rdy;  // write command gone after this edge
  assign error = state == S_ERROR;

  always_ff @(posedge bus_clk) begin
    if (coef_ack) grp_data[word_idx*XB_SIZE +: XB_SIZE] <= coef_word;
    if (grp_full) begin
      app_wdf_data <= grp_data[0 +: APP_DATA_WIDTH];  // words 0 and 1 are already in
    end else if (state == S_WR_WAIT && app_wdf_rdy) begin
      app_wdf_data <= grp_data[APP_DATA_WIDTH +: APP_DATA_WIDTH];
    end
  end

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state <= S_GATHER;
      word_idx <= '0;
      grp_last <= 1'b0;
      wr_addr <= START_ADDR;
      end_addr <= START_ADDR;
      app_addr <= START_ADDR;
      app_en <= 1'b0;
      dram_read <= 1'b0;
      app_wdf_wren <= 1'b0;
      app_wdf_end <= 1'b0;
    end else if (rd_overflow || pix_overflow) begin
      state <= S_ERROR;  // held until reset
      app_en <= 1'b0;
      app_wdf_wren <= 1'b0;
    end else begin
      case (state)
        S_GATHER:
          if (coef_ack) begin
            if (word_idx == '0) grp_last <= coef_word.coef.tag == TAG_COEFF_LAST;
            word_idx <= (word_idx == LAST_WORD) ? '0 : word_idx + 1'b1;
            if (grp_full) begin
              app_addr <= wr_addr;
              end_addr <= wr_addr;
              wr_addr <= wr_addr + STEP;
              app_en <= 1'b1;
              dram_read <= 1'b0;
              app_wdf_wren <= 1'b1;
              app_wdf_end <= 1'b0;
              state <= S_WR_WAIT;
            end
          end
        S_WR_WAIT: begin
          if (app_rdy) app_en <= 1'b0;
          if (app_wdf_rdy) begin
            app_wdf_end <= 1'b1;  // high beat closes the burst
            state <= S_WR2;
          end
        end
        S_WR2: begin
          if (app_rdy) app_en <= 1'b0;
          if (app_wdf_rdy) begin
            app_wdf_wren <= 1'b0;
            app_wdf_end <= 1'b0;
          end
          if ((app_wdf_rdy || !app_wdf_wren) && cmd_done) begin
            if (grp_last) begin
              app_addr <= START_ADDR;  // all groups stored, first readback pass
              dram_read <= 1'b1;
              app_en <= 1'b1;
              state <= S_READING;
            end else begin
              state <= S_GATHER;
            end
          end
        end
        S_READING:
          if (app_rdy) begin
            if (app_addr == end_addr) begin
              app_en <= 1'b0;
              state <= S_BETWEEN_FRAMES;
            end else begin
              app_addr <= app_addr + STEP;
              if (rd_high) begin  // readback FIFO has no back-pressure
                app_en <= 1'b0;
                state <= S_THROTTLED;
              end
            end
          end
        S_THROTTLED:
          if (!rd_high) begin
            app_en <= 1'b1;
            state <= S_READING;
          end
        S_BETWEEN_FRAMES:
          if (frame_start) begin
            app_addr <= START_ADDR;
            if (rd_high) begin
              state <= S_THROTTLED;
            end else begin
              app_en <= 1'b1;
              state <= S_READING;
            end
          end
        default: state <= S_ERROR;
      endcase
    end
  end

endmodule

// File: src/frame_tracker.sv
`timescale 1ns/1ps

module frame_tracker import patch_pkg::*; (
  input  logic                  bus_clk,
  input  logic                  fds_val,
  input  pc_msg_t               pix_word,
  input  logic                  pix_empty,
  output logic                  pix_ack,
  output logic                  pix_valid,
  output logic [PIX_SIZE-1:0]   pix_lo,
  output logic [PIX_SIZE-1:0]   pix_hi,
  output logic [ROW_SIZE-1:0]   pix_row,
  output logic [COL_SIZE-1:0]   pix_col,
  output logic [FRAME_SIZE-1:0] frame_count,
  output logic                  frame_start
);

  localparam logic [1:0] ST_STANDBY = 2'd0;
  localparam logic [1:0] ST_BETWEEN_FRAMES = 2'd1;
  localparam logic [1:0] ST_IN_LINE = 2'd2;
  localparam logic [1:0] ST_BETWEEN_LINES = 2'd3;
  localparam logic [COL_SIZE-1:0] COL_STEP = COL_SIZE'(2);  // two pixels per word

  logic [1:0] state;
  logic [ROW_SIZE-1:0] row_cnt;
  logic [COL_SIZE-1:0] col_cnt;  // column of the next word in the line
  logic report;

  assign pix_ack = !pix_empty;  // never hold the pixel stream back
  assign report = pix_ack && pix_word.pix.lval && state != ST_STANDBY;

  always_ff @(posedge bus_clk) begin
    if (report) begin
      pix_lo <= pix_word.pix.pix_lo;
      pix_hi <= pix_word.pix.pix_hi;
      pix_row <= (state == ST_BETWEEN_FRAMES) ? '0 : row_cnt;
      pix_col <= (state == ST_IN_LINE) ? col_cnt : '0;
    end
  end

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state <= ST_STANDBY;
      row_cnt <= '0;
      col_cnt <= '0;
      frame_count <= '0;
      pix_valid <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      pix_valid <= report;
      frame_start <= report && state == ST_BETWEEN_FRAMES;
      if (pix_ack) begin
        case (state)
          ST_STANDBY:
            if (!pix_word.pix.fval) begin  // sync up on a frame gap
              row_cnt <= '0;
              col_cnt <= '0;
              frame_count <= '0;
              state <= ST_BETWEEN_FRAMES;
            end
          ST_BETWEEN_FRAMES:
            if (pix_word.pix.lval) begin
              row_cnt <= '0;
              col_cnt <= COL_STEP;
              state <= ST_IN_LINE;
            end
          ST_IN_LINE:
            if (pix_word.pix.lval) begin
              col_cnt <= col_cnt + COL_STEP;
            end else if (pix_word.pix.fval) begin
              row_cnt <= row_cnt + 1'b1;
              state <= ST_BETWEEN_LINES;
            end else begin
              frame_count <= frame_count + 1'b1;
              state <= ST_BETWEEN_FRAMES;
            end
          default:
            if (pix_word.pix.lval) begin
              col_cnt <= COL_STEP;
              state <= ST_IN_LINE;
            end
        endcase
      end
    end
  end

endmodule

// File: src/msg_fifo.sv
`timescale 1ns/1ps

module msg_fifo #(
  parameter int WIDTH = 32,
  parameter int FIFO_DEPTH = 16,
  parameter int PROG_FULL = 12
) (
  input  logic             bus_clk,
  input  logic             fds_val,
  input  logic [WIDTH-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             high,
  output logic             overflow
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_LVL = CNT_W'(FIFO_DEPTH);
  localparam logic [CNT_W-1:0] HIGH_LVL = CNT_W'(PROG_FULL);

  logic [WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic full;
  logic do_wr;
  logic do_rd;

  assign full = count == FULL_LVL;
  assign empty = count == '0;
  assign high = count >= HIGH_LVL;
  assign dout = mem[rd_ptr];  // head entry shows while not empty
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge bus_clk) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
      if (wr_en && full) overflow <= 1'b1;  // sticky, word is dropped
    end
  end

endmodule

// File: src/msg_router.sv
`timescale 1ns/1ps

module msg_router import patch_pkg::*; (
  input  logic    bus_clk,
  input  logic    fds_val,
  input  pc_msg_t pc_msg,
  input  logic    pc_msg_empty,
  input  logic    pix_high,
  input  logic    coef_high,
  output logic    pc_msg_ack,
  output pc_msg_t fwd_word,
  output logic    pix_wr,
  output logic    coef_wr
);

  localparam int GRP_W = $clog2(WORDS_PER_GROUP);
  localparam logic [GRP_W-1:0] LAST_IN_GRP = GRP_W'(WORDS_PER_GROUP - 1);

  logic [GRP_W-1:0] grp_cnt;  // position inside the current coefficient group
  logic to_coef;

  // stall the host while either destination is close to full
  assign pc_msg_ack = !pc_msg_empty && !pix_high && !coef_high;

  // a tag-0 word in the middle of a group is still coefficient data
  assign to_coef = (grp_cnt != '0) || (pc_msg.coef.tag != TAG_PIXEL);

  always_ff @(posedge bus_clk) begin
    if (pc_msg_ack) fwd_word <= pc_msg;
  end

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      grp_cnt <= '0;
      pix_wr <= 1'b0;
      coef_wr <= 1'b0;
    end else begin
      pix_wr <= pc_msg_ack && !to_coef;
      coef_wr <= pc_msg_ack && to_coef;
      if (pc_msg_ack && to_coef) begin
        grp_cnt <= (grp_cnt == LAST_IN_GRP) ? '0 : grp_cnt + 1'b1;
      end
    end
  end

endmodule

// File: src/patch_app.sv
`timescale 1ns/1ps

module patch_app import patch_pkg::*; #(
  parameter int APP_DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 27,
  parameter logic [ADDR_WIDTH-1:0] START_ADDR = '0,
  parameter int MSG_FIFO_DEPTH = 16,
  parameter int COEF_FIFO_DEPTH = 32,
  parameter int COEF_PROG_FULL = 16
) (
  input  logic                      bus_clk,
  input  logic                      fds_val,
  input  pc_msg_t                   pc_msg,
  input  logic                      pc_msg_empty,
  output logic                      pc_msg_ack,
  input  logic                      app_rdy,
  output logic                      app_en,
  output logic                      dram_read,
  output logic [ADDR_WIDTH-1:0]     app_addr,
  input  logic                      app_wdf_rdy,
  output logic                      app_wdf_wren,
  output logic                      app_wdf_end,
  output logic [APP_DATA_WIDTH-1:0] app_wdf_data,
  input  logic                      app_rd_data_valid,
  input  logic [APP_DATA_WIDTH-1:0] app_rd_data,
  output logic                      pix_valid,
  output logic [PIX_SIZE-1:0]       pix_lo,
  output logic [PIX_SIZE-1:0]       pix_hi,
  output logic [ROW_SIZE-1:0]       pix_row,
  output logic [COL_SIZE-1:0]       pix_col,
  output logic [FRAME_SIZE-1:0]     frame_count,
  output logic                      frame_start,
  output logic [APP_DATA_WIDTH-1:0] coeff_data,
  output logic                      coeff_valid,
  input  logic                      coeff_ack,
  output logic                      error
);

  // router acks combinationally and pushes a cycle later, so leave two slots
  localparam int MSG_PROG_FULL = MSG_FIFO_DEPTH - 2;

  pc_msg_t fwd_word;
  pc_msg_t pix_word;
  pc_msg_t coef_word;
  logic pix_wr;
  logic coef_wr;
  logic pix_ack;
  logic pix_empty;
  logic pix_high;
  logic pix_overflow;
  logic coef_ack;
  logic coef_empty;
  logic coef_high;
  logic rd_empty;
  logic rd_high;
  logic rd_overflow;

  assign coeff_valid = !rd_empty;

  msg_router router0 (
    .bus_clk(bus_clk), .fds_val(fds_val),
    .pc_msg(pc_msg), .pc_msg_empty(pc_msg_empty), .pc_msg_ack(pc_msg_ack),
    .pix_high(pix_high), .coef_high(coef_high),
    .fwd_word(fwd_word), .pix_wr(pix_wr), .coef_wr(coef_wr)
  );

  msg_fifo #(.WIDTH(XB_SIZE), .FIFO_DEPTH(MSG_FIFO_DEPTH), .PROG_FULL(MSG_PROG_FULL)) pix_fifo (
    .bus_clk(bus_clk), .fds_val(fds_val),
    .din(fwd_word), .wr_en(pix_wr), .rd_en(pix_ack),
    .dout(pix_word), .empty(pix_empty), .high(pix_high), .overflow(pix_overflow)
  );

  msg_fifo #(.WIDTH(XB_SIZE), .FIFO_DEPTH(MSG_FIFO_DEPTH), .PROG_FULL(MSG_PROG_FULL)) coef_fifo (
    .bus_clk(bus_clk), .fds_val(fds_val),
    .din(fwd_word), .wr_en(coef_wr), .rd_en(coef_ack),
    .dout(coef_word), .empty(coef_empty), .high(coef_high), .overflow()
  );

  frame_tracker tracker0 (
    .bus_clk(bus_clk), .fds_val(fds_val),
    .pix_word(pix_word), .pix_empty(pix_empty), .pix_ack(pix_ack),
    .pix_valid(pix_valid), .pix_lo(pix_lo), .pix_hi(pix_hi),
    .pix_row(pix_row), .pix_col(pix_col),
    .frame_count(frame_count), .frame_start(frame_start)
  );

  dram_sequencer #(
    .APP_DATA_WIDTH(APP_DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .START_ADDR(START_ADDR)
  ) seq0 (
    .bus_clk(bus_clk), .fds_val(fds_val),
    .coef_word(coef_word), .coef_empty(coef_empty), .coef_ack(coef_ack),
    .app_rdy(app_rdy), .app_en(app_en), .dram_read(dram_read), .app_addr(app_addr),
    .app_wdf_rdy(app_wdf_rdy), .app_wdf_wren(app_wdf_wren),
    .app_wdf_end(app_wdf_end), .app_wdf_data(app_wdf_data),
    .rd_high(rd_high), .rd_overflow(rd_overflow), .pix_overflow(pix_overflow),
    .frame_start(frame_start), .error(error)
  );

  // read beats land here unconditionally, the sequencer throttles on high
  msg_fifo #(
    .WIDTH(APP_DATA_WIDTH), .FIFO_DEPTH(COEF_FIFO_DEPTH), .PROG_FULL(COEF_PROG_FULL)
  ) rd_fifo (
    .bus_clk(bus_clk), .fds_val(fds_val),
    .din(app_rd_data), .wr_en(app_rd_data_valid), .rd_en(coeff_ack),
    .dout(coeff_data), .empty(rd_empty), .high(rd_high), .overflow(rd_overflow)
  );

endmodule

// File: src/patch_pkg.sv
package patch_pkg;

  // host word and field sizes
  localparam int XB_SIZE = 32;          // host word, the union below is laid out for it
  localparam int PIX_SIZE = 12;         // one pixel as kept from the host word
  localparam int WORDS_PER_GROUP = 4;   // host words per two-beat DRAM burst
  localparam int ADDR_INC = 8;          // address step per burst

  // counter widths for the frame tracker
  localparam int ROW_SIZE = 12;
  localparam int COL_SIZE = 12;
  localparam int FRAME_SIZE = 16;

  typedef enum logic [1:0] {
    TAG_PIXEL      = 2'd0,
    TAG_COEFF      = 2'd1,
    TAG_COEFF_LAST = 2'd2  // first word of the final coefficient group
  } msg_tag_e;

  // one host word, read either as a pixel pair or as coefficient payload
  typedef union packed {
    struct packed {
      logic [PIX_SIZE-1:0] pix_hi;
      logic [PIX_SIZE-1:0] pix_lo;
      logic [3:0]          reserved;  // low pixel bits, dropped
      logic                fval;
      logic                lval;
      msg_tag_e            tag;
    } pix;
    struct packed {
      logic [XB_SIZE-3:0] payload;
      msg_tag_e           tag;
    } coef;
  } pc_msg_t;

endpackage

// File: test/dram_model.sv
`timescale 1ns/1ps

module dram_model #(
  parameter int APP_DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 27
) (
  input  logic                      bus_clk,
  input  logic                      fds_val,
  input  logic                      app_en,
  input  logic                      dram_read,
  input  logic [ADDR_WIDTH-1:0]     app_addr,
  input  logic                      app_wdf_wren,
  input  logic                      app_wdf_end,
  input  logic [APP_DATA_WIDTH-1:0] app_wdf_data,
  output logic                      app_rdy,
  output logic                      app_wdf_rdy,
  output logic                      app_rd_data_valid,
  output logic [APP_DATA_WIDTH-1:0] app_rd_data,
  output logic                      wdf_end_bad
);

  localparam int RD_DELAY = 3;  // cycles from read command to first beat

  integer seed;
  int cyc;
  logic [ADDR_WIDTH-1:0] wr_cmds [$];
  logic [APP_DATA_WIDTH-1:0] wr_beats [$];
  logic [APP_DATA_WIDTH-1:0] rd_beats [$];
  int rd_due [$];
  logic [2*APP_DATA_WIDTH-1:0] mem [16];  // one entry per burst address
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [APP_DATA_WIDTH-1:0] beat_lo;
  logic [APP_DATA_WIDTH-1:0] beat_hi;
  logic beat_odd;  // next write beat is the second of its burst

  initial begin
    seed = 87262;
    cyc = 0;
    beat_odd = 1'b0;
    wdf_end_bad = 1'b0;
    app_rdy = 1'b0;
    app_wdf_rdy = 1'b0;
    app_rd_data_valid = 1'b0;
    app_rd_data = '0;
  end

  // ready stalls and read beats change on the falling edge
  always @(negedge bus_clk) begin
    app_rdy = ($random(seed) & 3) != 0;      // stall about one cycle in four
    app_wdf_rdy = ($random(seed) & 3) != 0;
    if (rd_beats.size() > 0 && rd_due[0] <= cyc) begin
      app_rd_data_valid = 1'b1;
      app_rd_data = rd_beats.pop_front();
      void'(rd_due.pop_front());
    end else begin
      app_rd_data_valid = 1'b0;
    end
  end

  always @(posedge bus_clk) begin
    cyc++;
    if (!fds_val) begin
      if (app_en && app_rdy) begin
        if (dram_read) begin
          rd_beats.push_back(mem[app_addr[6:3]][APP_DATA_WIDTH-1:0]);
          rd_beats.push_back(mem[app_addr[6:3]][2*APP_DATA_WIDTH-1:APP_DATA_WIDTH]);
          rd_due.push_back(cyc + RD_DELAY);
          rd_due.push_back(cyc + RD_DELAY);
        end else begin
          wr_cmds.push_back(app_addr);
        end
      end
      if (app_wdf_wren && app_wdf_rdy) begin
        if (app_wdf_end != beat_odd) wdf_end_bad = 1'b1;  // end only on the second beat
        beat_odd = !beat_odd;
        wr_beats.push_back(app_wdf_data);
      end
      if (wr_cmds.size() > 0 && wr_beats.size() >= 2) begin  // burst complete
        cmd_addr = wr_cmds.pop_front();
        beat_lo = wr_beats.pop_front();
        beat_hi = wr_beats.pop_front();
        mem[cmd_addr[6:3]] = {beat_hi, beat_lo};
      end
    end
  end

endmodule

// File: test/patch_app_tb.sv
`timescale 1ns/1ps

module patch_app_tb import patch_pkg::*; ();

  localparam int DW = 64;
  localparam int AW = 27;
  localparam int N_ROWS = 24;
  localparam int N_A = 22;      // rows sent before the first readback
  localparam int N_BEATS = 6;   // beats per readback pass
  localparam int LIMIT = 20 * (N_ROWS + 2 * N_BEATS);

  logic bus_clk, fds_val, pc_msg_empty, pc_msg_ack, coeff_ack, coeff_valid, error;
  pc_msg_t pc_msg;
  logic app_rdy, app_en, dram_read, app_wdf_rdy, app_wdf_wren, app_wdf_end;
  logic app_rd_data_valid;
  logic wdf_end_bad;
  logic [AW-1:0] app_addr;
  logic [DW-1:0] app_wdf_data, app_rd_data, coeff_data;
  logic pix_valid, frame_start;
  logic [PIX_SIZE-1:0] pix_lo, pix_hi;
  logic [ROW_SIZE-1:0] pix_row;
  logic [COL_SIZE-1:0] pix_col;
  logic [FRAME_SIZE-1:0] frame_count;

  // stimulus table with expected pixel reports beside each word
  pc_msg_t tbl_word [N_ROWS];
  logic tbl_coef [N_ROWS];
  logic tbl_rep [N_ROWS];
  logic tbl_fs [N_ROWS];
  logic [ROW_SIZE-1:0] tbl_row [N_ROWS];
  logic [COL_SIZE-1:0] tbl_col [N_ROWS];
  logic [FRAME_SIZE-1:0] tbl_frame [N_ROWS];
  logic [DW-1:0] exp_beats [N_BEATS];
  pc_msg_t grp [4];
  int n_rows, n_reps, rep_idx, rep_seen, beat_cnt, cyc, i, k, nb;
  int rd_landed;  // read beats written into the readback FIFO
  logic hold_ack;

  patch_app #(.APP_DATA_WIDTH(DW), .ADDR_WIDTH(AW)) dut0 (
    .bus_clk(bus_clk), .fds_val(fds_val), .pc_msg(pc_msg), .pc_msg_empty(pc_msg_empty),
    .pc_msg_ack(pc_msg_ack), .app_rdy(app_rdy), .app_en(app_en), .dram_read(dram_read),
    .app_addr(app_addr), .app_wdf_rdy(app_wdf_rdy), .app_wdf_wren(app_wdf_wren),
    .app_wdf_end(app_wdf_end), .app_wdf_data(app_wdf_data),
    .app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data),
    .pix_valid(pix_valid), .pix_lo(pix_lo), .pix_hi(pix_hi), .pix_row(pix_row),
    .pix_col(pix_col), .frame_count(frame_count), .frame_start(frame_start),
    .coeff_data(coeff_data), .coeff_valid(coeff_valid), .coeff_ack(coeff_ack),
    .error(error)
  );

  dram_model #(.APP_DATA_WIDTH(DW), .ADDR_WIDTH(AW)) model0 (
    .bus_clk(bus_clk), .fds_val(fds_val), .app_en(app_en), .dram_read(dram_read),
    .app_addr(app_addr), .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end),
    .app_wdf_data(app_wdf_data), .app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
    .app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data),
    .wdf_end_bad(wdf_end_bad)
  );

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic stop_run(input string msg);
    $display("%s at %0t ns", msg, $time);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
  endtask

  task automatic check_beat(input logic [DW-1:0] got, input logic [DW-1:0] exp, input int n);
    if (got !== exp) report_mismatch($sformatf("beat %0d is %h, expected %h", n, got, exp));
  endtask

  task automatic check_pix(input logic [PIX_SIZE-1:0] lo, input logic [PIX_SIZE-1:0] hi,
                           input logic [ROW_SIZE-1:0] row, input logic [COL_SIZE-1:0] col,
                           input logic [FRAME_SIZE-1:0] frame, input logic fs, input int r);
    if (lo !== tbl_word[r].pix.pix_lo || hi !== tbl_word[r].pix.pix_hi || row !== tbl_row[r]
        || col !== tbl_col[r] || frame !== tbl_frame[r] || fs !== tbl_fs[r])
      report_mismatch($sformatf("row %0d report lo %h hi %h r %0d c %0d f %0d fs %b", r, lo, hi,
                                row, col, frame, fs));
  endtask

  task automatic add_pix(input int hi, input int lo, input int fv, input int lv, input int rep,
                         input int fs, input int row, input int col, input int frame);
    pc_msg_t w;
    w.pix.pix_hi = PIX_SIZE'(hi);
    w.pix.pix_lo = PIX_SIZE'(lo);
    w.pix.reserved = 4'h0;
    w.pix.fval = fv != 0;
    w.pix.lval = lv != 0;
    w.pix.tag = TAG_PIXEL;
    tbl_word[n_rows] = w;
    tbl_coef[n_rows] = 1'b0;
    tbl_rep[n_rows] = rep != 0;
    tbl_fs[n_rows] = fs != 0;
    tbl_row[n_rows] = ROW_SIZE'(row);
    tbl_col[n_rows] = COL_SIZE'(col);
    tbl_frame[n_rows] = FRAME_SIZE'(frame);
    n_rows++;
  endtask

  task automatic add_coef(input int payload, input msg_tag_e tag);
    tbl_word[n_rows].coef.payload = 30'(payload);
    tbl_word[n_rows].coef.tag = tag;
    tbl_coef[n_rows] = 1'b1;
    tbl_rep[n_rows] = 1'b0;
    tbl_fs[n_rows] = 1'b0;
    n_rows++;
  endtask

  // offer one word and hold it until the router takes it
  task automatic send_word(input pc_msg_t w);
    pc_msg = w;
    pc_msg_empty = 1'b0;
    #1;
    while (!pc_msg_ack) begin
      @(negedge bus_clk);
      #1;
    end
    @(negedge bus_clk);
    pc_msg_empty = 1'b1;
  endtask

  task automatic wait_beats(input int n);
    while (beat_cnt < n) @(negedge bus_clk);
  endtask

  initial begin
    bus_clk = 1'b0;
    forever #50 bus_clk = ~bus_clk;
  end

  always @(posedge bus_clk) begin
    cyc++;
    if (app_rd_data_valid) rd_landed++;
    if (cyc >= LIMIT) stop_run($sformatf("run timed out after %0d cycles", cyc));
  end

  // outputs are sampled and readback ack is driven on the falling edge
  always @(negedge bus_clk) begin
    if (!fds_val) begin
      check_flag("error", error, 1'b0);
      check_flag("app_wdf_end on a write beat", wdf_end_bad, 1'b0);
      if (pix_valid) begin
        while (rep_idx < N_ROWS && !tbl_rep[rep_idx]) rep_idx++;
        if (rep_idx >= N_ROWS) stop_run("pixel report arrived with none expected");
        check_pix(pix_lo, pix_hi, pix_row, pix_col, frame_count, frame_start, rep_idx);
        rep_idx++;
        rep_seen++;
      end else begin
        check_flag("frame_start without report", frame_start, 1'b0);
      end
      if (coeff_valid && !hold_ack) begin
        if (beat_cnt >= 2 * N_BEATS) stop_run("readback beat arrived with none expected");
        check_beat(coeff_data, exp_beats[beat_cnt % N_BEATS], beat_cnt);
        beat_cnt++;
        coeff_ack = 1'b1;
      end else begin
        coeff_ack = 1'b0;
      end
    end
  end

  initial begin
    fds_val = 1'b1;
    pc_msg = '0;
    pc_msg_empty = 1'b1;
    coeff_ack = 1'b0;
    hold_ack = 1'b1;
    {n_rows, n_reps, rep_idx, rep_seen, beat_cnt, cyc, nb, k} = '0;
    add_pix(0, 0, 0, 0, 0, 0, 0, 0, 0);  // frame gap syncs the tracker
    add_pix('h101, 'h102, 1, 1, 1, 1, 0, 0, 0);
    add_pix('h103, 'h104, 1, 1, 1, 0, 0, 2, 0);
    add_pix(0, 0, 1, 0, 0, 0, 0, 0, 0);
    add_pix('h111, 'h112, 1, 1, 1, 0, 1, 0, 0);
    add_pix('h113, 'h114, 1, 1, 1, 0, 1, 2, 0);
    add_pix(0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_coef('h0a0, TAG_COEFF);
    add_coef('h0a1, TAG_COEFF);
    add_coef('h0a2, TAG_COEFF);
    add_coef('h0a3, TAG_COEFF);
    add_coef('h1b0, TAG_COEFF);
    add_coef('h1b1, TAG_PIXEL);    // tag 0 inside a group stays coefficient data
    add_coef('h1b2, TAG_COEFF);
    add_coef('h1b3, TAG_COEFF);
    add_pix('h201, 'h202, 1, 1, 1, 1, 0, 0, 1);
    add_pix('h203, 'h204, 1, 1, 1, 0, 0, 2, 1);
    add_pix(0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_coef('h2c0, TAG_COEFF_LAST);
    add_coef('h2c1, TAG_COEFF);
    add_coef('h2c2, TAG_COEFF);
    add_coef('h2c3, TAG_COEFF);
    add_pix('h301, 'h302, 1, 1, 1, 1, 0, 0, 2);  // new frame restarts readback
    add_pix(0, 0, 0, 0, 0, 0, 0, 0, 0);
    for (i = 0; i < N_ROWS; i++) begin
      if (tbl_rep[i]) n_reps++;
      if (tbl_coef[i]) begin
        grp[k] = tbl_word[i];
        k++;
        if (k == 4) begin
          exp_beats[nb] = {grp[1], grp[0]};
          exp_beats[nb + 1] = {grp[3], grp[2]};
          nb += 2;
          k = 0;
        end
      end
    end
    repeat (4) @(negedge bus_clk);
    fds_val = 1'b0;
    #1;
    check_flag("pc_msg_ack after reset", pc_msg_ack, 1'b0);
    check_flag("app_en after reset", app_en, 1'b0);
    check_flag("app_wdf_wren after reset", app_wdf_wren, 1'b0);
    check_flag("pix_valid after reset", pix_valid, 1'b0);
    check_flag("coeff_valid after reset", coeff_valid, 1'b0);
    check_flag("error after reset", error, 1'b0);
    @(negedge bus_clk);
    for (i = 0; i < N_A; i++) send_word(tbl_word[i]);
    while (rd_landed < N_BEATS) @(negedge bus_clk);  // readback piles up with coeff_ack low
    hold_ack = 1'b0;
    wait_beats(N_BEATS);
    for (i = N_A; i < N_ROWS; i++) send_word(tbl_word[i]);
    wait_beats(2 * N_BEATS);
    repeat (8) @(negedge bus_clk);  // room for a stray beat to show up
    check_flag("error at end", error, 1'b0);
    if (rep_seen != n_reps) begin
      stop_run($sformatf("saw %0d pixel reports, not %0d", rep_seen, n_reps));
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule
